//--- Makefile
# Verilator build and run of the ADC capture testbench

VERILATOR ?= verilator
TOP       ?= adc_capture_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+logic
logic/adc_capture_pkg.sv
logic/adc_sysref_gen.sv
logic/adc_lane_deframer.sv
logic/adc_sample_fifo.sv
logic/adc_credit_port.sv
logic/adc_capture_top.sv
test/adc_capture_tb.sv

//--- logic/adc_capture_params.svh
`ifndef ADC_CAPTURE_PARAMS_SVH
`define ADC_CAPTURE_PARAMS_SVH

// **************************************************
// Capture path sizing
// **************************************************

// SYSREF period in core clock cycles
// The output is high for one half and low for the other, so keep it even
`define ADC_SYSREF_PERIOD 16

// Number of sample beats the capture FIFO can hold
// A beat arriving while all entries are taken is dropped
`define ADC_FIFO_DEPTH 8

// Credits the sink grants after reset
// Each credit stands for one beat buffer on the DMA side
`define ADC_CREDIT_INIT 4

`endif

//--- logic/adc_capture_pkg.sv
package adc_capture_pkg;

  // **************************************************
  // Lane side
  // **************************************************

  // One word recovered from a serial lane
  // The data holds two 16 bit samples and the older one sits in bits 15:0
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } lane_word_t;

  // Both lanes as they arrive together in one core clock cycle
  typedef struct packed {
    lane_word_t lane1;
    lane_word_t lane0;
  } lane_pair_t;

  // **************************************************
  // Sample side
  // **************************************************

  // Four samples in time order, sample[0] being the oldest
  // Samples 0 and 1 come from lane 0, samples 2 and 3 from lane 1
  // sysref_mark flags the first beat captured at or after a SYSREF edge
  typedef struct packed {
    logic             sysref_mark;
    logic [3:0][15:0] sample;
  } sample_beat_t;

endpackage

//--- logic/adc_capture_top.sv
`timescale 1ns/10ps

module adc_capture_top (
  input  logic                          core_clk_i,
  input  logic                          rst_i,
  input  adc_capture_pkg::lane_pair_t   lane_i,
  input  logic                          sysref_en_i,
  input  logic                          fmt_twos_i,
  input  logic                          credit_return_i,
  output logic                          out_valid_o,
  output adc_capture_pkg::sample_beat_t out_o,
  output logic                          sysref_o,
  output logic                          skew_err_o,
  output logic                          overflow_o
);

  import adc_capture_pkg::*;

  logic         beat_valid;
  sample_beat_t beat;
  sample_beat_t fifo_head;
  logic         fifo_not_empty;
  logic         fifo_pop;

  // **************************************************
  // SYSREF generation
  // **************************************************

  // The same SYSREF that goes to the converter also marks the beats
  adc_sysref_gen i_sysref_gen (
    .core_clk_i  (core_clk_i),
    .rst_i       (rst_i),
    .sysref_en_i (sysref_en_i),
    .sysref_o    (sysref_o));

  // **************************************************
  // Sample path
  // **************************************************

  adc_lane_deframer i_lane_deframer (
    .core_clk_i   (core_clk_i),
    .rst_i        (rst_i),
    .lane_i       (lane_i),
    .fmt_twos_i   (fmt_twos_i),
    .sysref_i     (sysref_o),
    .beat_valid_o (beat_valid),
    .beat_o       (beat),
    .skew_err_o   (skew_err_o));

  adc_sample_fifo i_sample_fifo (
    .core_clk_i  (core_clk_i),
    .rst_i       (rst_i),
    .push_i      (beat_valid),
    .push_beat_i (beat),
    .pop_i       (fifo_pop),
    .head_o      (fifo_head),
    .not_empty_o (fifo_not_empty),
    .overflow_o  (overflow_o));

  adc_credit_port i_credit_port (
    .core_clk_i      (core_clk_i),
    .rst_i           (rst_i),
    .head_i          (fifo_head),
    .not_empty_i     (fifo_not_empty),
    .pop_o           (fifo_pop),
    .credit_return_i (credit_return_i),
    .out_valid_o     (out_valid_o),
    .out_o           (out_o));

endmodule

//--- logic/adc_credit_port.sv
`timescale 1ns/10ps

`include "adc_capture_params.svh"

module adc_credit_port (
  input  logic                          core_clk_i,
  input  logic                          rst_i,
  input  adc_capture_pkg::sample_beat_t head_i,
  input  logic                          not_empty_i,
  output logic                          pop_o,
  input  logic                          credit_return_i,
  output logic                          out_valid_o,
  output adc_capture_pkg::sample_beat_t out_o
);

  localparam int unsigned CREDIT_INIT = `ADC_CREDIT_INIT;
  localparam int unsigned CRED_W = $clog2(CREDIT_INIT + 1);
  localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(CREDIT_INIT);

  logic [CRED_W-1:0] credits;
  logic              send;

  // A beat leaves whenever there is one waiting and the sink has room
  assign send  = not_empty_i & (credits != '0);
  assign pop_o = send;

  always_ff @(posedge core_clk_i) begin
    if (rst_i) begin
      credits     <= CRED_MAX;
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= send;
      // A send and a return in the same cycle leave the count unchanged
      case ({send, credit_return_i})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (send) begin
      out_o <= head_i;
    end
  end

  // **************************************************
  // Sink protocol checks
  // **************************************************

  a_credit_bound: assert property (
    @(posedge core_clk_i) disable iff (rst_i)
    credits <= CRED_MAX
  );

  // The sink can only give back credits for beats it has received
  a_no_spare_return: assert property (
    @(posedge core_clk_i) disable iff (rst_i)
    credit_return_i |-> (credits != CRED_MAX)
  );

endmodule

//--- logic/adc_lane_deframer.sv
`timescale 1ns/10ps

module adc_lane_deframer (
  input  logic                          core_clk_i,
  input  logic                          rst_i,
  input  adc_capture_pkg::lane_pair_t   lane_i,
  input  logic                          fmt_twos_i,
  input  logic                          sysref_i,
  output logic                          beat_valid_o,
  output adc_capture_pkg::sample_beat_t beat_o,
  output logic                          skew_err_o
);

  import adc_capture_pkg::*;

  logic         both_valid;
  logic         one_valid;
  logic         sysref_d;
  logic         sysref_rise;
  logic         mark_pending;
  logic [15:0]  msb_flip;
  sample_beat_t beat_next;

  assign both_valid  = lane_i.lane0.valid & lane_i.lane1.valid;
  assign one_valid   = lane_i.lane0.valid ^ lane_i.lane1.valid;
  assign sysref_rise = sysref_i & ~sysref_d;

  // Flipping the MSB turns offset binary into two's complement
  assign msb_flip = {fmt_twos_i, 15'd0};

  // **************************************************
  // Beat assembly
  // **************************************************

  always_comb begin
    beat_next.sample[0]   = lane_i.lane0.data[15:0] ^ msb_flip;
    beat_next.sample[1]   = lane_i.lane0.data[31:16] ^ msb_flip;
    beat_next.sample[2]   = lane_i.lane1.data[15:0] ^ msb_flip;
    beat_next.sample[3]   = lane_i.lane1.data[31:16] ^ msb_flip;
    // An edge seen in a cycle without data is carried to the next beat
    beat_next.sysref_mark = sysref_rise | mark_pending;
  end

  always_ff @(posedge core_clk_i) begin
    if (rst_i) begin
      sysref_d     <= 1'b0;
      mark_pending <= 1'b0;
      beat_valid_o <= 1'b0;
      skew_err_o   <= 1'b0;
    end else begin
      sysref_d     <= sysref_i;
      beat_valid_o <= both_valid;
      if (one_valid) begin
        skew_err_o <= 1'b1;
      end
      if (both_valid) begin
        mark_pending <= 1'b0;
      end else if (sysref_rise) begin
        mark_pending <= 1'b1;
      end
    end
  end

  // A cycle with only one lane valid never reaches the FIFO
  always_ff @(posedge core_clk_i) begin
    if (both_valid) begin
      beat_o <= beat_next;
    end
  end

endmodule

//--- logic/adc_sample_fifo.sv
`timescale 1ns/10ps

`include "adc_capture_params.svh"

module adc_sample_fifo (
  input  logic                          core_clk_i,
  input  logic                          rst_i,
  input  logic                          push_i,
  input  adc_capture_pkg::sample_beat_t push_beat_i,
  input  logic                          pop_i,
  output adc_capture_pkg::sample_beat_t head_o,
  output logic                          not_empty_o,
  output logic                          overflow_o
);

  import adc_capture_pkg::*;

  localparam int unsigned DEPTH = `ADC_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  sample_beat_t     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push_ok;

  assign full        = (count == CNT_FULL);
  assign push_ok     = push_i & ~full;
  assign not_empty_o = (count != '0);
  assign head_o      = mem[rd_ptr];

  // **************************************************
  // Pointers, occupancy and overflow
  // **************************************************

  always_ff @(posedge core_clk_i) begin
    if (rst_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // The ADC cannot be stalled, so a lost beat is only reported
      if (push_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_beat_i;
    end
  end

  // The credit port must only pop an entry it has seen at the head
  a_no_pop_when_empty: assert property (
    @(posedge core_clk_i) disable iff (rst_i)
    pop_i |-> not_empty_o
  );

endmodule

//--- logic/adc_sysref_gen.sv
`timescale 1ns/10ps

`include "adc_capture_params.svh"

module adc_sysref_gen (
  input  logic core_clk_i,
  input  logic rst_i,
  input  logic sysref_en_i,
  output logic sysref_o
);

  localparam int unsigned PERIOD = `ADC_SYSREF_PERIOD;
  localparam int unsigned CNT_W = $clog2(PERIOD);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PERIOD - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(PERIOD / 2);

  logic [CNT_W-1:0] cnt;

  // The counter only runs while SYSREF is enabled, so every enable starts
  // a fresh period with the high half first
  always_ff @(posedge core_clk_i) begin
    if (rst_i) begin
      cnt      <= '0;
      sysref_o <= 1'b0;
    end else if (sysref_en_i) begin
      sysref_o <= (cnt < CNT_HALF);
      if (cnt == CNT_LAST) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end else begin
      cnt      <= '0;
      sysref_o <= 1'b0;
    end
  end

  // SYSREF may only be driven out when the processor had it enabled
  // on the previous edge
  a_sysref_needs_enable: assert property (
    @(posedge core_clk_i) disable iff (rst_i)
    !$past(sysref_en_i) |-> !sysref_o
  );

endmodule

//--- test/adc_capture_tb.sv
`timescale 1ns/10ps

`include "adc_capture_params.svh"

module adc_capture_tb;

  import adc_capture_pkg::*;

  localparam int TIMEOUT     = 300;
  localparam int NUM_ENTRIES = 46;
  localparam int HALF_PERIOD = `ADC_SYSREF_PERIOD / 2;

  // One row of the stimulus table
  typedef struct packed {
    lane_pair_t lanes;
    logic       fmt;
    logic [3:0] idle;
  } stim_t;

  logic         core_clk_i = 1'b0;
  logic         rst_i;
  lane_pair_t   lane_i;
  logic         sysref_en_i;
  logic         fmt_twos_i;
  logic         credit_return_i = 1'b0;
  logic         out_valid_o;
  sample_beat_t out_o;
  logic         sysref_o;
  logic         skew_err_o;
  logic         overflow_o;

  stim_t        tbl [NUM_ENTRIES];
  string        tbl_name [NUM_ENTRIES];
  integer       seed;
  sample_beat_t exp_q [$];
  string        name_q [$];
  string        cur_name;
  logic         returning;
  logic         ret_next = 1'b0;
  logic         sysref_seen = 1'b0;
  logic         mark_pending = 1'b0;
  int           owed = 0;
  int           rx_count = 0;
  int           mark_count = 0;
  int           push_total = 0;
  int           push_limit;

  adc_capture_top adc_capture_top_inst (
    .core_clk_i      (core_clk_i),
    .rst_i           (rst_i),
    .lane_i          (lane_i),
    .sysref_en_i     (sysref_en_i),
    .fmt_twos_i      (fmt_twos_i),
    .credit_return_i (credit_return_i),
    .out_valid_o     (out_valid_o),
    .out_o           (out_o),
    .sysref_o        (sysref_o),
    .skew_err_o      (skew_err_o),
    .overflow_o      (overflow_o));

  always #5 core_clk_i = ~core_clk_i;

  // **************************************************
  // Failure reporting
  // **************************************************

  task automatic end_run_failed();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR: %s", msg);
    end_run_failed();
  endtask

  task automatic report_mismatch(input string test, input logic [64:0] expected,
                                 input logic [64:0] actual);
    $display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
    end_run_failed();
  endtask

  // **************************************************
  // Reference model
  // **************************************************

  // Lane 0 then lane 1, low half first in each, MSB flipped for two's complement
  function automatic sample_beat_t predict_beat(input lane_pair_t lp, input logic twos,
                                                input logic mark);
    sample_beat_t b;
    logic [63:0]  words;
    logic [15:0]  s;
    words = {lp.lane1.data, lp.lane0.data};
    for (int j = 0; j < 4; j++) begin
      s = words[16*j +: 16];
      if (twos) begin
        s[15] = ~s[15];
      end
      b.sample[j] = s;
    end
    b.sysref_mark = mark;
    return b;
  endfunction

  // Sink checks first, then the model looks at what the DUT samples next
  always @(negedge core_clk_i) begin : sink_and_model
    sample_beat_t exp_beat;
    string        exp_name;
    logic         rise;
    logic         mark;
    if (!rst_i) begin
      if (out_valid_o) begin
        assert (exp_q.size() > 0)
          else report_problem($sformatf("beat %h delivered with none expected", out_o));
        if (exp_q.size() > 0) begin
          exp_beat = exp_q.pop_front();
          exp_name = name_q.pop_front();
          assert (out_o === exp_beat)
            else report_mismatch(exp_name, exp_beat, out_o);
          rx_count++;
          owed++;
        end
      end
      ret_next = 1'b0;
      if (returning && owed > 0) begin
        ret_next = 1'b1;
        owed--;
      end
      rise = sysref_o && !sysref_seen;
      if (lane_i.lane0.valid && lane_i.lane1.valid) begin
        mark = rise || mark_pending;
        mark_pending = 1'b0;
        // Past the limit the FIFO is full and the beat is lost
        if (push_limit < 0 || push_total < push_limit) begin
          exp_q.push_back(predict_beat(lane_i, fmt_twos_i, mark));
          name_q.push_back(cur_name);
          if (mark) begin
            mark_count++;
          end
        end
        push_total++;
      end else if (rise) begin
        mark_pending = 1'b1;
      end
      sysref_seen = sysref_o;
    end
  end

  always @(posedge core_clk_i) begin
    credit_return_i <= ret_next;
  end

  // **************************************************
  // Stimulus table
  // **************************************************

  task automatic fill_entries(input int first, input int last, input string name,
                              input logic fmt, input logic [3:0] idle_mask);
    for (int i = first; i <= last; i++) begin
      tbl_name[i]             = name;
      tbl[i].lanes.lane0.valid = 1'b1;
      tbl[i].lanes.lane0.data  = $random(seed);
      tbl[i].lanes.lane1.valid = 1'b1;
      tbl[i].lanes.lane1.data  = $random(seed);
      tbl[i].fmt               = fmt;
      tbl[i].idle              = 4'($random(seed)) & idle_mask;
    end
  endtask

  task automatic apply_range(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      @(posedge core_clk_i);
      cur_name = tbl_name[i];
      lane_i     <= tbl[i].lanes;
      fmt_twos_i <= tbl[i].fmt;
      for (int k = 0; k < int'(tbl[i].idle); k++) begin
        @(posedge core_clk_i);
        lane_i <= '0;
      end
    end
    @(posedge core_clk_i);
    lane_i <= '0;
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || owed != 0) && n < TIMEOUT) begin
      @(posedge core_clk_i);
      n++;
    end
    assert (exp_q.size() == 0 && owed == 0)
      else report_problem($sformatf("timed out draining beats in %s", what));
    repeat (4) @(posedge core_clk_i);
  endtask

  task automatic wait_rx(input int target, input string what);
    int n;
    n = 0;
    while (rx_count < target && n < TIMEOUT) begin
      @(posedge core_clk_i);
      n++;
    end
    assert (rx_count >= target)
      else report_problem($sformatf("timed out waiting for beats in %s", what));
  endtask

  // Counts the negedges during which SYSREF holds the given level
  task automatic measure_level(input logic level, output int len);
    len = 0;
    while (sysref_o == level && len < TIMEOUT) begin
      len++;
      @(negedge core_clk_i);
    end
  endtask

  // **************************************************
  // Test sequence
  // **************************************************

  initial begin : main_seq
    int n;
    int hi_len;
    int lo_len;
    int rx_before;
    int mark_before;
    seed        = 32'hb3cb;
    rst_i       = 1'b1;
    lane_i      = '0;
    sysref_en_i = 1'b0;
    fmt_twos_i  = 1'b0;
    returning   = 1'b1;
    push_limit  = -1;
    cur_name    = "reset";
    fill_entries(0, 5, "order_fmt0", 1'b0, 4'd3);
    fill_entries(6, 11, "order_fmt1", 1'b1, 4'd3);
    fill_entries(12, 23, "sysref_mark", 1'b0, 4'd3);
    fill_entries(24, 29, "credit_limit", 1'b1, 4'd0);
    fill_entries(30, 44, "overflow", 1'b0, 4'd0);
    fill_entries(45, 45, "lane_skew", 1'b0, 4'd0);
    tbl[45].lanes.lane1.valid = 1'b0;
    tbl[45].idle              = 4'd2;

    repeat (5) @(posedge core_clk_i);
    rst_i <= 1'b0;
    @(negedge core_clk_i);
    assert (!out_valid_o && !sysref_o && !skew_err_o && !overflow_o)
      else report_problem("outputs are not all low after reset");

    apply_range(0, 11);
    wait_drain("sample order");

    // SYSREF waveform over two full periods
    cur_name = "sysref_wave";
    @(posedge core_clk_i);
    sysref_en_i <= 1'b1;
    n = 0;
    while (!sysref_o && n < TIMEOUT) begin
      @(negedge core_clk_i);
      n++;
    end
    assert (sysref_o) else report_problem("SYSREF never rose after enable");
    repeat (2) begin
      measure_level(1'b1, hi_len);
      assert (hi_len == HALF_PERIOD)
        else report_mismatch("sysref_wave high", 65'(HALF_PERIOD), 65'(hi_len));
      measure_level(1'b0, lo_len);
      assert (lo_len == HALF_PERIOD)
        else report_mismatch("sysref_wave low", 65'(HALF_PERIOD), 65'(lo_len));
    end

    mark_before = mark_count;
    apply_range(12, 23);
    wait_drain("sysref mark");
    assert (mark_count > mark_before) else report_problem("no beat carried a SYSREF mark");

    cur_name = "sysref_off";
    @(posedge core_clk_i);
    sysref_en_i <= 1'b0;
    n = 0;
    while (sysref_o && n < 3) begin
      @(negedge core_clk_i);
      n++;
    end
    repeat (`ADC_SYSREF_PERIOD) begin
      assert (!sysref_o) else report_problem("SYSREF still high after enable dropped");
      @(negedge core_clk_i);
    end

    // Credit limit with the sink holding back all credits
    returning = 1'b0;
    rx_before = rx_count;
    apply_range(24, 29);
    wait_rx(rx_before + `ADC_CREDIT_INIT, "credit limit");
    repeat (12) @(posedge core_clk_i);
    assert (rx_count == rx_before + `ADC_CREDIT_INIT)
      else report_mismatch("credit_limit", 65'(rx_before + `ADC_CREDIT_INIT), 65'(rx_count));
    returning = 1'b1;
    wait_drain("credit limit");

    // Overflow with more beats than FIFO and credits can hold
    assert (!overflow_o) else report_problem("overflow flag set too early");
    returning  = 1'b0;
    rx_before  = rx_count;
    push_limit = push_total + `ADC_FIFO_DEPTH + `ADC_CREDIT_INIT;
    apply_range(30, 44);
    n = 0;
    while (!overflow_o && n < TIMEOUT) begin
      @(negedge core_clk_i);
      n++;
    end
    assert (overflow_o) else report_problem("overflow flag never set");
    wait_rx(rx_before + `ADC_CREDIT_INIT, "overflow");
    returning = 1'b1;
    wait_drain("overflow");
    push_limit = -1;
    assert (rx_count == rx_before + `ADC_FIFO_DEPTH + `ADC_CREDIT_INIT)
      else report_mismatch("overflow",
                           65'(rx_before + `ADC_FIFO_DEPTH + `ADC_CREDIT_INIT), 65'(rx_count));

    // A single valid lane gives no beat and a sticky skew error
    assert (!skew_err_o) else report_problem("skew error set too early");
    rx_before = rx_count;
    apply_range(45, 45);
    n = 0;
    while (!skew_err_o && n < TIMEOUT) begin
      @(negedge core_clk_i);
      n++;
    end
    assert (skew_err_o) else report_problem("skew error never set");
    repeat (6) @(posedge core_clk_i);
    assert (rx_count == rx_before)
      else report_mismatch("lane_skew", 65'(rx_before), 65'(rx_count));

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
